// ==== files.f ====
+incdir+source
+incdir+test
source/mipsPkg.sv
source/controller.sv
source/alu.sv
source/registerFile.sv
source/dataMemory.sv
source/fetchUnit.sv
source/mipsCore.sv
test/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module mipsCoreTb -Mdir obj_dir -o simMipsCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simMipsCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] readDataA,
    input  logic [`DATA_WIDTH-1:0] readDataB,
    input  logic [15:0]            immediate,
    input  logic [4:0]             shamt,
    input  mipsPkg::aluOpT         aluOp,
    input  logic                   aluSrc,
    input  logic                   immZeroExtend,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic                   equal,
    output logic                   isZero,
    output logic                   positive,
    output logic                   negative
);

    logic [`DATA_WIDTH-1:0] extendedImm;
    logic [`DATA_WIDTH-1:0] operandB;
    logic                   lessThan;

    // Operand B selection
    assign extendedImm = immZeroExtend ? {16'b0, immediate}
                                       : {{16{immediate[15]}}, immediate};
    assign operandB = aluSrc ? extendedImm : readDataB;
    assign lessThan = $signed(readDataA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            mipsPkg::AluAdd: aluResult = readDataA + operandB;
            mipsPkg::AluSub: aluResult = readDataA - operandB;
            mipsPkg::AluAnd: aluResult = readDataA & operandB;
            mipsPkg::AluOr:  aluResult = readDataA | operandB;
            mipsPkg::AluXor: aluResult = readDataA ^ operandB;
            mipsPkg::AluNor: aluResult = ~(readDataA | operandB);
            mipsPkg::AluSlt: aluResult = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            // Shifts act on rt by shamt
            mipsPkg::AluSll: aluResult = operandB << shamt;
            mipsPkg::AluSrl: aluResult = operandB >> shamt;
            // Low word of the product
            mipsPkg::AluMul: aluResult = readDataA * operandB;
            default:         aluResult = readDataA + operandB;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch flags, always from the register values
    ////////////////////////////////////////////////////////////
    assign equal    = readDataA == readDataB;
    assign isZero   = readDataA == '0;
    assign negative = readDataA[`DATA_WIDTH-1];
    assign positive = !negative && !isZero;

endmodule

// ==== source/controller.sv ====
`timescale 1ns/1ps

module controller (
    input  logic [5:0]           opcode,
    input  logic [5:0]           funct,
    input  logic [4:0]           rtField,
    input  logic                 equal,
    input  logic                 isZero,
    input  logic                 positive,
    input  logic                 negative,
    output mipsPkg::aluOpT       aluOp,
    output logic                 aluSrc,
    output logic                 immZeroExtend,
    output logic                 regWrite,
    output mipsPkg::regDstT      regDst,
    output mipsPkg::writeSelT    writeSel,
    output logic                 memWrite,
    output logic                 memRead,
    output mipsPkg::accessSizeT  accessSize,
    output logic                 branchTaken,
    output logic                 jump,
    output logic                 jumpReg
);

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        aluOp         = mipsPkg::AluAdd;
        aluSrc        = 1'b0;
        immZeroExtend = 1'b0;
        regWrite      = 1'b0;
        regDst        = mipsPkg::DstRt;
        writeSel      = mipsPkg::WbAlu;
        memWrite      = 1'b0;
        memRead       = 1'b0;
        accessSize    = mipsPkg::SizeWord;
        branchTaken   = 1'b0;
        jump          = 1'b0;
        jumpReg       = 1'b0;

        case (mipsPkg::opcodeT'(opcode))
            ////////////////////////////////////////////////////////////
            // Register forms
            ////////////////////////////////////////////////////////////
            mipsPkg::OpSpecial: begin
                regDst   = mipsPkg::DstRd;
                regWrite = 1'b1;
                case (mipsPkg::functT'(funct))
                    mipsPkg::FnAdd: aluOp = mipsPkg::AluAdd;
                    mipsPkg::FnSub: aluOp = mipsPkg::AluSub;
                    mipsPkg::FnAnd: aluOp = mipsPkg::AluAnd;
                    mipsPkg::FnOr:  aluOp = mipsPkg::AluOr;
                    mipsPkg::FnXor: aluOp = mipsPkg::AluXor;
                    mipsPkg::FnNor: aluOp = mipsPkg::AluNor;
                    mipsPkg::FnSlt: aluOp = mipsPkg::AluSlt;
                    mipsPkg::FnSll: aluOp = mipsPkg::AluSll;
                    mipsPkg::FnSrl: aluOp = mipsPkg::AluSrl;
                    mipsPkg::FnJr: begin
                        regWrite = 1'b0;
                        jumpReg  = 1'b1;
                    end
                    // Unknown function, no-op
                    default: regWrite = 1'b0;
                endcase
            end
            mipsPkg::OpSpecial2: begin
                if (funct == mipsPkg::FnMul) begin
                    aluOp    = mipsPkg::AluMul;
                    regDst   = mipsPkg::DstRd;
                    regWrite = 1'b1;
                end
            end

            ////////////////////////////////////////////////////////////
            // Immediate forms, result goes to rt
            ////////////////////////////////////////////////////////////
            mipsPkg::OpAddi, mipsPkg::OpSlti,
            mipsPkg::OpAndi, mipsPkg::OpOri, mipsPkg::OpXori: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (mipsPkg::opcodeT'(opcode))
                    mipsPkg::OpSlti: aluOp = mipsPkg::AluSlt;
                    mipsPkg::OpAndi: aluOp = mipsPkg::AluAnd;
                    mipsPkg::OpOri:  aluOp = mipsPkg::AluOr;
                    mipsPkg::OpXori: aluOp = mipsPkg::AluXor;
                    default:         aluOp = mipsPkg::AluAdd;
                endcase
                // Logical immediates are zero-extended
                immZeroExtend = opcode != mipsPkg::OpAddi && opcode != mipsPkg::OpSlti;
            end

            // Loads, address is rs plus offset
            mipsPkg::OpLw, mipsPkg::OpLh, mipsPkg::OpLb: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                writeSel = mipsPkg::WbMemory;
                if (opcode == mipsPkg::OpLh) accessSize = mipsPkg::SizeHalf;
                if (opcode == mipsPkg::OpLb) accessSize = mipsPkg::SizeByte;
            end

            // Stores
            mipsPkg::OpSw, mipsPkg::OpSh, mipsPkg::OpSb: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                if (opcode == mipsPkg::OpSh) accessSize = mipsPkg::SizeHalf;
                if (opcode == mipsPkg::OpSb) accessSize = mipsPkg::SizeByte;
            end

            ////////////////////////////////////////////////////////////
            // Branches and jumps
            ////////////////////////////////////////////////////////////
            mipsPkg::OpBeq:  branchTaken = equal;
            mipsPkg::OpBne:  branchTaken = !equal;
            mipsPkg::OpBgtz: branchTaken = positive;
            mipsPkg::OpBlez: branchTaken = negative || isZero;
            // rt selects BLTZ (0) or BGEZ (1)
            mipsPkg::OpRegimm: begin
                case (rtField)
                    5'd0:    branchTaken = negative;
                    5'd1:    branchTaken = positive || isZero;
                    default: branchTaken = 1'b0;
                endcase
            end
            mipsPkg::OpJ: jump = 1'b1;
            mipsPkg::OpJal: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                regDst   = mipsPkg::DstLink;
                writeSel = mipsPkg::WbLink;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/dataMemory.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module dataMemory (
    input  logic                   Clk,
    input  logic [`DATA_WIDTH-1:0] address,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   memWrite,
    input  logic                   memRead,
    input  mipsPkg::accessSizeT    accessSize,
    output logic [`DATA_WIDTH-1:0] loadData
);

    localparam int AddrBits = $clog2(`DMEM_BYTES);

    logic [7:0]          bytes [`DMEM_BYTES];
    logic [AddrBits-1:0] lane0;
    logic [AddrBits-1:0] lane1;
    logic [AddrBits-1:0] lane2;
    logic [AddrBits-1:0] lane3;
    logic [`DATA_WIDTH-1:0] readWord;

    // Little-endian lanes, wrapping at the memory size
    assign lane0 = address[AddrBits-1:0];
    assign lane1 = lane0 + AddrBits'(1);
    assign lane2 = lane0 + AddrBits'(2);
    assign lane3 = lane0 + AddrBits'(3);

    always_comb begin
        case (accessSize)
            mipsPkg::SizeHalf: readWord = {{16{bytes[lane1][7]}}, bytes[lane1], bytes[lane0]};
            mipsPkg::SizeByte: readWord = {{24{bytes[lane0][7]}}, bytes[lane0]};
            default:           readWord = {bytes[lane3], bytes[lane2],
                                           bytes[lane1], bytes[lane0]};
        endcase
    end

    assign loadData = memRead ? readWord : '0;

    ////////////////////////////////////////////////////////////
    // Byte-lane masked writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (memWrite) begin
            bytes[lane0] <= writeData[7:0];
            if (accessSize != mipsPkg::SizeByte) begin
                bytes[lane1] <= writeData[15:8];
            end
            if (accessSize == mipsPkg::SizeWord) begin
                bytes[lane2] <= writeData[23:16];
                bytes[lane3] <= writeData[31:24];
            end
        end
    end

endmodule

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module fetchUnit (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] instruction,
    input  logic [`DATA_WIDTH-1:0] readDataA,
    input  logic                   branchTaken,
    input  logic                   jump,
    input  logic                   jumpReg,
    output logic [`DATA_WIDTH-1:0] instrAddress,
    output logic [`DATA_WIDTH-1:0] linkAddress
);

    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] branchTarget;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic [`DATA_WIDTH-1:0] nextPc;

    assign instrAddress = pc;
    assign linkAddress  = pc + 32'd4;

    // Word offset relative to the following instruction
    assign branchTarget = linkAddress + {{14{instruction[15]}}, instruction[15:0], 2'b00};
    // Region bits come from PC plus 4
    assign jumpTarget   = {linkAddress[31:28], instruction[25:0], 2'b00};

    always_comb begin
        if (jumpReg)          nextPc = readDataA;
        else if (jump)        nextPc = jumpTarget;
        else if (branchTaken) nextPc = branchTarget;
        else                  nextPc = linkAddress;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= `PC_RESET;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== source/mipsConfig.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath width
`define DATA_WIDTH 32

// Architectural register count
`define REG_COUNT 32

// Data memory size in bytes, addresses wrap at this size
`define DMEM_BYTES 256

// First instruction fetched after reset
`define PC_RESET 32'h0000_0000

`endif

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module mipsCore (
    input  logic                   Clk,
    input  logic                   reset,
    output logic [`DATA_WIDTH-1:0] instrAddress,
    input  logic [`DATA_WIDTH-1:0] instruction,
    output logic                   regWriteEnable,
    output logic [4:0]             regWriteAddress,
    output logic [`DATA_WIDTH-1:0] regWriteData,
    output logic                   memWriteEnable,
    output logic [`DATA_WIDTH-1:0] memAddress,
    output logic [`DATA_WIDTH-1:0] memWriteData,
    output mipsPkg::accessSizeT    memSize
);

    logic [`DATA_WIDTH-1:0] linkAddress, readDataA, readDataB, aluResult, loadData;
    logic                   equal, isZero, positive, negative;
    logic                   aluSrc, immZeroExtend, regWrite, memWrite, memRead;
    logic                   branchTaken, jump, jumpReg;
    mipsPkg::aluOpT         aluOp;
    mipsPkg::regDstT        regDst;
    mipsPkg::writeSelT      writeSel;

    ////////////////////////////////////////////////////////////
    // Datapath blocks
    ////////////////////////////////////////////////////////////
    fetchUnit fetch (
        .Clk(Clk), .reset(reset), .instruction(instruction), .readDataA(readDataA),
        .branchTaken(branchTaken), .jump(jump), .jumpReg(jumpReg),
        .instrAddress(instrAddress), .linkAddress(linkAddress)
    );

    controller control (
        .opcode(instruction[31:26]), .funct(instruction[5:0]), .rtField(instruction[20:16]),
        .equal(equal), .isZero(isZero), .positive(positive), .negative(negative),
        .aluOp(aluOp), .aluSrc(aluSrc), .immZeroExtend(immZeroExtend),
        .regWrite(regWrite), .regDst(regDst), .writeSel(writeSel),
        .memWrite(memWrite), .memRead(memRead), .accessSize(memSize),
        .branchTaken(branchTaken), .jump(jump), .jumpReg(jumpReg)
    );

    alu execute (
        .readDataA(readDataA), .readDataB(readDataB), .immediate(instruction[15:0]),
        .shamt(instruction[10:6]), .aluOp(aluOp), .aluSrc(aluSrc),
        .immZeroExtend(immZeroExtend), .aluResult(aluResult), .equal(equal),
        .isZero(isZero), .positive(positive), .negative(negative)
    );

    registerFile registers (
        .Clk(Clk), .reset(reset), .rsAddress(instruction[25:21]),
        .rtAddress(instruction[20:16]), .rdAddress(instruction[15:11]),
        .regWrite(regWrite), .regDst(regDst), .writeSel(writeSel),
        .aluResult(aluResult), .loadData(loadData), .linkAddress(linkAddress),
        .readDataA(readDataA), .readDataB(readDataB), .regWriteEnable(regWriteEnable),
        .regWriteAddress(regWriteAddress), .regWriteData(regWriteData)
    );

    // Store trace mirrors the memory inputs, quiet during reset
    assign memWriteEnable = memWrite && !reset;
    assign memAddress     = aluResult;
    assign memWriteData   = readDataB;

    dataMemory memory (
        .Clk(Clk), .address(memAddress), .writeData(memWriteData),
        .memWrite(memWriteEnable), .memRead(memRead), .accessSize(memSize),
        .loadData(loadData)
    );

endmodule

// ==== source/mipsPkg.sv ====
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OpSpecial  = 6'h00,
        OpRegimm   = 6'h01,
        OpJ        = 6'h02,
        OpJal      = 6'h03,
        OpBeq      = 6'h04,
        OpBne      = 6'h05,
        OpBlez     = 6'h06,
        OpBgtz     = 6'h07,
        OpAddi     = 6'h08,
        OpSlti     = 6'h0A,
        OpAndi     = 6'h0C,
        OpOri      = 6'h0D,
        OpXori     = 6'h0E,
        OpSpecial2 = 6'h1C,
        OpLb       = 6'h20,
        OpLh       = 6'h21,
        OpLw       = 6'h23,
        OpSb       = 6'h28,
        OpSh       = 6'h29,
        OpSw       = 6'h2B
    } opcodeT;

    // Function field, bits 5:0
    typedef enum logic [5:0] {
        FnSll = 6'h00,
        FnSrl = 6'h02,
        FnJr  = 6'h08,
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24,
        FnOr  = 6'h25,
        FnXor = 6'h26,
        FnNor = 6'h27,
        FnSlt = 6'h2A
    } functT;

    // MUL under SPECIAL2 shares its code with SRL
    localparam functT FnMul = FnSrl;

    ////////////////////////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor,
        AluNor, AluSlt, AluSll, AluSrl, AluMul
    } aluOpT;

    // DstLink always targets register 31
    typedef enum logic [1:0] {DstRt, DstRd, DstLink} regDstT;

    typedef enum logic [1:0] {WbAlu, WbMemory, WbLink} writeSelT;

    typedef enum logic [1:0] {SizeWord, SizeHalf, SizeByte} accessSizeT;

endpackage

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module registerFile (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic [4:0]             rsAddress,
    input  logic [4:0]             rtAddress,
    input  logic [4:0]             rdAddress,
    input  logic                   regWrite,
    input  mipsPkg::regDstT        regDst,
    input  mipsPkg::writeSelT      writeSel,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  logic [`DATA_WIDTH-1:0] loadData,
    input  logic [`DATA_WIDTH-1:0] linkAddress,
    output logic [`DATA_WIDTH-1:0] readDataA,
    output logic [`DATA_WIDTH-1:0] readDataB,
    output logic                   regWriteEnable,
    output logic [4:0]             regWriteAddress,
    output logic [`DATA_WIDTH-1:0] regWriteData
);

    logic [`DATA_WIDTH-1:0] registers [`REG_COUNT];

    assign regWriteAddress = regDst == mipsPkg::DstRd   ? rdAddress :
                             regDst == mipsPkg::DstLink ? 5'd31 : rtAddress;
    assign regWriteData = writeSel == mipsPkg::WbMemory ? loadData :
                          writeSel == mipsPkg::WbLink   ? linkAddress : aluResult;
    // Register 0 is never written
    assign regWriteEnable = regWrite && regWriteAddress != 5'd0 && !reset;

    assign readDataA = rsAddress == 5'd0 ? '0 : registers[rsAddress];
    assign readDataB = rtAddress == 5'd0 ? '0 : registers[rtAddress];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (regWriteEnable) begin
            registers[regWriteAddress] <= regWriteData;
        end
    end

endmodule

// ==== test/tbProgram.svh ====
// Register model of the program where register 0 stays zero
logic [31:0] model [`REG_COUNT];
int          romCount;

// addi r30, r0, 0x0bad in the slot a taken branch or jump skips
localparam logic [31:0] SkipSlot = 32'h201e_0bad;

function automatic logic [31:0] encodeR(input logic [5:0] op, input logic [4:0] rs, rt, rd,
                                        input logic [4:0] sa, input logic [5:0] fn);
    return {op, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
endfunction

// Places a word in the next ROM slot and returns its address
function automatic logic [31:0] place(input logic [31:0] word);
    rom[romCount] = word;
    romCount++;
    return 32'((romCount - 1) * 4);
endfunction

// Expected result of an ALU instruction
function automatic logic [31:0] resultOf(input logic [31:0] word, input logic [31:0] a, b);
    logic [31:0] imm;
    logic [31:0] immZero;
    logic [4:0]  sa;
    imm     = {{16{word[15]}}, word[15:0]};
    immZero = {16'h0000, word[15:0]};
    sa      = word[10:6];
    case (word[31:26])
        mipsPkg::OpSpecial2: return a * b;
        mipsPkg::OpAddi:     return a + imm;
        mipsPkg::OpSlti:     return {31'd0, $signed(a) < $signed(imm)};
        mipsPkg::OpAndi:     return a & immZero;
        mipsPkg::OpOri:      return a | immZero;
        mipsPkg::OpXori:     return a ^ immZero;
        default: ;
    endcase
    case (word[5:0])
        mipsPkg::FnAdd: return a + b;
        mipsPkg::FnSub: return a - b;
        mipsPkg::FnAnd: return a & b;
        mipsPkg::FnOr:  return a | b;
        mipsPkg::FnXor: return a ^ b;
        mipsPkg::FnNor: return ~(a | b);
        mipsPkg::FnSlt: return {31'd0, $signed(a) < $signed(b)};
        mipsPkg::FnSll: return b << sa;
        mipsPkg::FnSrl: return b >> sa;
        default:        return 32'd0;
    endcase
endfunction

task automatic record(input string name, input logic [31:0] pc, input logic [4:0] dest,
                      input logic [31:0] value, input logic memEn = 1'b0,
                      input logic [31:0] memAddr = 32'd0, input logic [31:0] memData = 32'd0,
                      input logic [1:0] memSize = 2'd0);
    stepT step;
    step         = '0;
    step.pc      = pc;
    step.regEn   = dest != 5'd0;
    step.regAddr = dest;
    step.regData = value;
    step.memEn   = memEn;
    step.memAddr = memAddr;
    step.memData = memData;
    step.memSize = memSize;
    if (dest != 5'd0) begin
        model[dest] = value;
    end
    traceQ.push_back(step);
    nameQ.push_back(name);
endtask

task automatic execute(input string name, input logic [31:0] word);
    logic [31:0] pc;
    logic [4:0]  dest;
    pc = place(word);
    // Register forms write rd and immediate forms write rt
    dest = (word[31:26] == mipsPkg::OpSpecial || word[31:26] == mipsPkg::OpSpecial2) ?
           word[15:11] : word[20:16];
    record(name, pc, dest, resultOf(word, model[word[25:21]], model[word[20:16]]));
endtask

// Store followed by a load of the same size from the same address
task automatic memoryPair(input string name, input logic [5:0] storeOp, loadOp,
                          input logic [4:0] src, dst, base, input logic [15:0] offset);
    logic [31:0]         pc;
    logic [31:0]         addr;
    logic [31:0]         stored;
    logic [31:0]         loaded;
    mipsPkg::accessSizeT size;
    addr = model[base] + {{16{offset[15]}}, offset};
    size = storeOp == mipsPkg::OpSw ? mipsPkg::SizeWord :
           storeOp == mipsPkg::OpSh ? mipsPkg::SizeHalf : mipsPkg::SizeByte;
    stored = model[src] & sizeMask(size);
    loaded = stored;
    if (size == mipsPkg::SizeHalf) begin
        loaded = {{16{stored[15]}}, stored[15:0]};
    end
    if (size == mipsPkg::SizeByte) begin
        loaded = {{24{stored[7]}}, stored[7:0]};
    end
    pc = place(encodeI(storeOp, base, src, offset));
    record({name, " store"}, pc, 5'd0, 32'd0, 1'b1, addr, stored, size);
    pc = place(encodeI(loadOp, base, dst, offset));
    record({name, " load"}, pc, dst, loaded);
endtask

// Branch over one slot that runs only on fall-through
task automatic branch(input string name, input logic [5:0] op, input logic [4:0] rs, rt);
    logic [31:0] pc;
    logic        taken;
    case (op)
        mipsPkg::OpBeq:  taken = model[rs] == model[rt];
        mipsPkg::OpBne:  taken = model[rs] != model[rt];
        mipsPkg::OpBgtz: taken = $signed(model[rs]) > 0;
        mipsPkg::OpBlez: taken = $signed(model[rs]) <= 0;
        // Under REGIMM rt 1 is BGEZ and rt 0 is BLTZ
        default:         taken = rt == 5'd1 ? $signed(model[rs]) >= 0 : $signed(model[rs]) < 0;
    endcase
    pc = place(encodeI(op, rs, rt, 16'd1));
    record(name, pc, 5'd0, 32'd0);
    pc = place(SkipSlot);
    if (!taken) begin
        record({name, " fall-through"}, pc, 5'd30, 32'h0000_0bad);
    end
endtask

task automatic jumpTo(input string name, input logic [5:0] op);
    logic [31:0] pc;
    pc = 32'(romCount * 4);
    void'(place(encodeJ(op, 26'((pc + 32'd8) >> 2))));
    // JAL links to the following instruction
    record(name, pc, op == mipsPkg::OpJal ? 5'd31 : 5'd0, pc + 32'd4);
    void'(place(SkipSlot));
endtask

task automatic jumpRegister(input string name, input logic [4:0] rs);
    logic [31:0] pc;
    // Target lies past the JR and its skipped slot
    execute({name, " target"}, encodeI(mipsPkg::OpAddi, 5'd0, rs, 16'(romCount * 4 + 12)));
    pc = place(encodeR(mipsPkg::OpSpecial, rs, 5'd0, 5'd0, 5'd0, mipsPkg::FnJr));
    record(name, pc, 5'd0, 32'd0);
    void'(place(SkipSlot));
endtask

////////////////////////////////////////////////////////////
// Directed program
////////////////////////////////////////////////////////////
task automatic buildProgram();
    logic [15:0] imm [4];
    for (int i = 0; i < 256; i++) begin
        // Unused slots hold addi r0, r0, index
        rom[i] = encodeI(mipsPkg::OpAddi, 5'd0, 5'd0, 16'(i));
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
        model[i] = 32'd0;
    end
    for (int i = 0; i < 4; i++) begin
        // Bit 15 set so sign and zero extension give different results
        imm[i] = 16'($urandom) | 16'h8000;
    end
    romCount = 0;
    execute("nop", 32'h0000_0000);
    execute("addi", encodeI(mipsPkg::OpAddi, 5'd0, 5'd1, imm[0]));
    execute("ori", encodeI(mipsPkg::OpOri, 5'd0, 5'd2, imm[1]));
    execute("andi", encodeI(mipsPkg::OpAndi, 5'd1, 5'd3, imm[2]));
    execute("xori", encodeI(mipsPkg::OpXori, 5'd2, 5'd4, imm[3]));
    execute("addi negative", encodeI(mipsPkg::OpAddi, 5'd0, 5'd6, 16'hfffb));
    execute("addi positive", encodeI(mipsPkg::OpAddi, 5'd0, 5'd7, 16'h0005));
    execute("add", encodeR(mipsPkg::OpSpecial, 5'd1, 5'd2, 5'd8, 5'd0, mipsPkg::FnAdd));
    execute("sub", encodeR(mipsPkg::OpSpecial, 5'd1, 5'd2, 5'd9, 5'd0, mipsPkg::FnSub));
    execute("and", encodeR(mipsPkg::OpSpecial, 5'd1, 5'd4, 5'd10, 5'd0, mipsPkg::FnAnd));
    execute("or", encodeR(mipsPkg::OpSpecial, 5'd1, 5'd4, 5'd11, 5'd0, mipsPkg::FnOr));
    execute("xor", encodeR(mipsPkg::OpSpecial, 5'd3, 5'd4, 5'd12, 5'd0, mipsPkg::FnXor));
    execute("nor", encodeR(mipsPkg::OpSpecial, 5'd3, 5'd4, 5'd13, 5'd0, mipsPkg::FnNor));
    execute("slt true", encodeR(mipsPkg::OpSpecial, 5'd6, 5'd7, 5'd14, 5'd0, mipsPkg::FnSlt));
    execute("slt false", encodeR(mipsPkg::OpSpecial, 5'd7, 5'd6, 5'd15, 5'd0, mipsPkg::FnSlt));
    execute("sll", encodeR(mipsPkg::OpSpecial, 5'd0, 5'd6, 5'd16, 5'd4, mipsPkg::FnSll));
    execute("srl", encodeR(mipsPkg::OpSpecial, 5'd0, 5'd6, 5'd17, 5'd4, mipsPkg::FnSrl));
    execute("mul", encodeR(mipsPkg::OpSpecial2, 5'd6, 5'd7, 5'd18, 5'd0, mipsPkg::FnMul));
    execute("slti", encodeI(mipsPkg::OpSlti, 5'd6, 5'd19, 16'hfffe));
    execute("add to r0", encodeR(mipsPkg::OpSpecial, 5'd1, 5'd2, 5'd0, 5'd0, mipsPkg::FnAdd));
    execute("base", encodeI(mipsPkg::OpAddi, 5'd0, 5'd20, 16'h0040));
    memoryPair("word", mipsPkg::OpSw, mipsPkg::OpLw, 5'd8, 5'd21, 5'd20, 16'h0000);
    memoryPair("half", mipsPkg::OpSh, mipsPkg::OpLh, 5'd6, 5'd22, 5'd20, 16'h0006);
    memoryPair("byte", mipsPkg::OpSb, mipsPkg::OpLb, 5'd2, 5'd23, 5'd20, 16'hfffb);
    branch("beq taken", mipsPkg::OpBeq, 5'd7, 5'd7);
    branch("beq not taken", mipsPkg::OpBeq, 5'd6, 5'd7);
    branch("bne taken", mipsPkg::OpBne, 5'd6, 5'd7);
    branch("bne not taken", mipsPkg::OpBne, 5'd7, 5'd7);
    branch("bgtz taken", mipsPkg::OpBgtz, 5'd7, 5'd0);
    branch("bgtz not taken", mipsPkg::OpBgtz, 5'd6, 5'd0);
    branch("blez taken", mipsPkg::OpBlez, 5'd6, 5'd0);
    branch("blez zero taken", mipsPkg::OpBlez, 5'd0, 5'd0);
    branch("blez not taken", mipsPkg::OpBlez, 5'd7, 5'd0);
    branch("bgez taken", mipsPkg::OpRegimm, 5'd0, 5'd1);
    branch("bgez not taken", mipsPkg::OpRegimm, 5'd6, 5'd1);
    branch("bltz taken", mipsPkg::OpRegimm, 5'd6, 5'd0);
    branch("bltz not taken", mipsPkg::OpRegimm, 5'd7, 5'd0);
    jumpTo("j", mipsPkg::OpJ);
    jumpTo("jal", mipsPkg::OpJal);
    jumpRegister("jr", 5'd5);
    execute("final nop", 32'h0000_0000);
endtask

// ==== test/mipsCoreTb.sv ====
`timescale 1ns/1ps
`include "mipsConfig.svh"

module mipsCoreTb;

    // One executed instruction of the expected trace
    typedef struct packed {
        logic [31:0] pc;
        logic        regEn;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memEn;
        logic [31:0] memAddr;
        logic [31:0] memData;
        logic [1:0]  memSize;
    } stepT;

    logic                Clk = 1'b0;
    logic                reset;
    logic [31:0]         instrAddress;
    logic [31:0]         instruction;
    logic                regWriteEnable;
    logic [4:0]          regWriteAddress;
    logic [31:0]         regWriteData;
    logic                memWriteEnable;
    logic [31:0]         memAddress;
    logic [31:0]         memWriteData;
    mipsPkg::accessSizeT memSize;

    logic [31:0] rom [256];
    stepT        traceQ[$];
    string       nameQ[$];
    stepT        expected;
    string       currentName;
    logic        checking;
    logic        probeStore;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    logic [36:0] regSeen;
    logic [65:0] storeSeen;

    function automatic logic [31:0] sizeMask(input logic [1:0] size);
        case (size)
            mipsPkg::SizeHalf: return 32'h0000_ffff;
            mipsPkg::SizeByte: return 32'h0000_00ff;
            default:           return 32'hffff_ffff;
        endcase
    endfunction

    `include "tbProgram.svh"

    mipsCore UUT (
        .Clk(Clk), .reset(reset), .instrAddress(instrAddress), .instruction(instruction),
        .regWriteEnable(regWriteEnable), .regWriteAddress(regWriteAddress),
        .regWriteData(regWriteData), .memWriteEnable(memWriteEnable),
        .memAddress(memAddress), .memWriteData(memWriteData), .memSize(memSize)
    );

    always #10 Clk = ~Clk;

    // Instruction ROM answers in the same cycle
    // During reset the port offers a register write and a store in turn
    assign instruction = !reset     ? rom[instrAddress[9:2]] :
                         probeStore ? encodeI(mipsPkg::OpSw, 5'd0, 5'd1, 16'd0) :
                                      encodeI(mipsPkg::OpAddi, 5'd0, 5'd1, 16'd1);

    assign regSeen   = {regWriteAddress, regWriteData};
    assign storeSeen = {memAddress, memWriteData & sizeMask(expected.memSize), 2'(memSize)};

    task automatic reportMismatch(input string check, input logic [95:0] want, got);
        errorCount++;
        $display("mismatch %s (%s): expected %0h, actual %0h", currentName, check, want, got);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////
    // Checks on every rising edge
    ////////////////////////////////////////////////////////////
    pcCheck: assert property (@(posedge Clk) disable iff (!checking)
            instrAddress == expected.pc)
        else reportMismatch("instrAddress", 96'($sampled(expected.pc)),
                            96'($sampled(instrAddress)));

    regEnableCheck: assert property (@(posedge Clk) disable iff (!checking)
            regWriteEnable == expected.regEn)
        else reportMismatch("regWriteEnable", 96'($sampled(expected.regEn)),
                            96'($sampled(regWriteEnable)));

    // Address and data only matter on a write
    regWriteCheck: assert property (@(posedge Clk) disable iff (!checking)
            !expected.regEn || regSeen == {expected.regAddr, expected.regData})
        else reportMismatch("register write", 96'($sampled({expected.regAddr, expected.regData})),
                            96'($sampled(regSeen)));

    memEnableCheck: assert property (@(posedge Clk) disable iff (!checking)
            memWriteEnable == expected.memEn)
        else reportMismatch("memWriteEnable", 96'($sampled(expected.memEn)),
                            96'($sampled(memWriteEnable)));

    storeCheck: assert property (@(posedge Clk) disable iff (!checking)
            !expected.memEn || storeSeen == {expected.memAddr, expected.memData, expected.memSize})
        else reportMismatch("store", 96'($sampled({expected.memAddr, expected.memData,
                            expected.memSize})), 96'($sampled(storeSeen)));

    // Guard against a run that never drains the trace
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d trace steps never ran", cycleCount,
                     traceQ.size());
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset then one trace step per cycle
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hc70a82f9));
        reset       = 1'b1;
        probeStore  = 1'b0;
        checking    = 1'b0;
        expected    = '0;
        expected.pc = `PC_RESET;
        currentName = "reset";
        buildProgram();
        cycleLimit = 10 + traceQ.size() + 40;

        // PC is unknown until the first reset edge
        @(posedge Clk);
        #1 checking = 1'b1;
        repeat (9) begin
            @(posedge Clk);
            #1 probeStore = !probeStore;
        end
        reset = 1'b0;

        while (traceQ.size() > 0) begin
            expected    = traceQ.pop_front();
            currentName = nameQ.pop_front();
            @(posedge Clk);
            #1;
        end
        checking = 1'b0;

        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
